// ==== dcache_pkg.sv ====
package dcache_pkg;

	// physical address and bus word
	localparam int ADDR_BITS = 32;
	localparam int DATA_BITS = 64;
	localparam int STRB_BITS = DATA_BITS / 8;

	// line geometry: 16 lines of four 64-bit words
	localparam int ALIGN_BITS = 3;
	localparam int OFFSET_BITS = 5;
	localparam int INDEX_BITS = 4;
	localparam int TAG_BITS = 28 - OFFSET_BITS - INDEX_BITS;
	localparam int WORD_BITS = OFFSET_BITS - ALIGN_BITS;
	localparam int WORDS_PER_LINE = 4;
	localparam int NUM_LINES = 2 ** INDEX_BITS;

	// only this 256 MB window is cached
	localparam logic [3:0] CACHED_REGION = 4'd8;

	// transfer size codes
	localparam logic [2:0] MSIZE1 = 3'd0;
	localparam logic [2:0] MSIZE2 = 3'd1;
	localparam logic [2:0] MSIZE4 = 3'd2;
	localparam logic [2:0] MSIZE8 = 3'd3;

	// burst type codes
	localparam logic [1:0] BURST_FIXED = 2'd0;
	localparam logic [1:0] BURST_INCR = 2'd1;

	// beat count minus one
	localparam logic [3:0] LEN_SINGLE = 4'd0;
	localparam logic [3:0] LEN_LINE = 4'd3;

	// one address word, seen raw or split into cache fields
	typedef union packed {
		logic [ADDR_BITS-1:0] raw;
		struct packed {
			logic [3:0] region;
			logic [TAG_BITS-1:0] tag;
			logic [INDEX_BITS-1:0] index;
			logic [WORD_BITS-1:0] word;
			logic [ALIGN_BITS-1:0] byte_off;
		} f;
	} dcache_addr_u;

endpackage

// ==== dcache_ram.sv ====
`timescale 1ns/1ps

module dcache_ram #(
	parameter int ADDR_WIDTH = 4,
	parameter int DATA_WIDTH = 64,
	parameter int BYTE_WIDTH = 8,
	parameter int READ_LATENCY = 1
) (
	input logic clk,
	input logic [ADDR_WIDTH-1:0] addr,
	input logic [DATA_WIDTH/BYTE_WIDTH-1:0] strobe,
	input logic [DATA_WIDTH-1:0] wdata,
	output logic [DATA_WIDTH-1:0] rdata
);

	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

	// each strobe bit writes one slice of the word
	always_ff @(posedge clk) begin
		for (int i = 0; i < DATA_WIDTH / BYTE_WIDTH; i++) begin
			if (strobe[i]) begin
				mem[addr][i*BYTE_WIDTH +: BYTE_WIDTH] <= wdata[i*BYTE_WIDTH +: BYTE_WIDTH];
			end
		end
	end

	generate
		if (READ_LATENCY == 0) begin : g_comb_read
			// read-during-write returns the old word
			assign rdata = mem[addr];
		end else begin : g_reg_read
			always_ff @(posedge clk) begin
				rdata <= mem[addr];
			end
		end
	endgenerate

	a_read_latency: assert property (
		@(posedge clk) READ_LATENCY == 0 || READ_LATENCY == 1
	) else $error("dcache_ram: read latency %0d not supported", READ_LATENCY);

endmodule

// ==== dcache_wb_buffer.sv ====
`timescale 1ns/1ps

module dcache_wb_buffer
	import dcache_pkg::*;
(
	input logic clk,
	input logic wr_en,
	input logic [WORD_BITS-1:0] wr_word,
	input logic [DATA_BITS-1:0] wdata,
	input logic [WORD_BITS-1:0] rd_word,
	output logic [DATA_BITS-1:0] rdata
);

	// victim line, filled during the copy phase
	logic [DATA_BITS-1:0] line_q [WORDS_PER_LINE];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			line_q[wr_word] <= wdata;
		end
	end

	// combinational read so a write beat never waits on the data RAM
	assign rdata = line_q[rd_word];

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl
	import dcache_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic dreq_valid,
	input logic [ADDR_BITS-1:0] dreq_addr,
	input logic [2:0] dreq_size,
	input logic [STRB_BITS-1:0] dreq_strobe,
	input logic [DATA_BITS-1:0] dreq_data,
	output logic dresp_data_ok,
	output logic [DATA_BITS-1:0] dresp_data,

	output logic creq_valid,
	output logic creq_is_write,
	output logic [2:0] creq_size,
	output logic [ADDR_BITS-1:0] creq_addr,
	output logic [STRB_BITS-1:0] creq_strobe,
	output logic [DATA_BITS-1:0] creq_data,
	output logic [3:0] creq_len,
	output logic [1:0] creq_burst,
	input logic cresp_ready,
	input logic cresp_last,
	input logic [DATA_BITS-1:0] cresp_data,

	output logic [INDEX_BITS-1:0] tag_addr,
	output logic tag_wen,
	output logic [TAG_BITS:0] tag_wdata,
	input logic [TAG_BITS:0] tag_rdata,

	output logic [INDEX_BITS+WORD_BITS-1:0] data_addr,
	output logic [STRB_BITS-1:0] data_wen,
	output logic [DATA_BITS-1:0] data_wdata,
	input logic [DATA_BITS-1:0] data_rdata,

	output logic wb_wr_en,
	output logic [WORD_BITS-1:0] wb_wr_word,
	output logic [WORD_BITS-1:0] wb_rd_word,
	input logic [DATA_BITS-1:0] wb_rdata
);

	localparam logic [2:0] CLEAR = 3'd0;
	localparam logic [2:0] IDLE = 3'd1;
	localparam logic [2:0] HIT_RESP = 3'd2;
	localparam logic [2:0] COPY = 3'd3;
	localparam logic [2:0] WRITEBACK = 3'd4;
	localparam logic [2:0] FETCH = 3'd5;
	localparam logic [2:0] UNCACHED = 3'd6;
	localparam logic [2:0] UNC_RESP = 3'd7;

	logic [2:0] state;
	logic [2:0] state_nxt;
	// clear sweep index, copy step or burst beat, depending on state
	logic [INDEX_BITS-1:0] cnt;
	logic [INDEX_BITS-1:0] cnt_nxt;
	logic [DATA_BITS-1:0] unc_data;

	dcache_addr_u req;
	logic cached;
	logic line_valid;
	logic [TAG_BITS-1:0] line_tag;
	logic hit;
	logic beat_done;
	logic unc_st;

	assign req.raw = dreq_addr;
	assign cached = req.f.region == CACHED_REGION;

	// tag entry is {valid, tag}
	assign line_valid = tag_rdata[TAG_BITS];
	assign line_tag = tag_rdata[TAG_BITS-1:0];
	assign hit = line_valid && line_tag == req.f.tag;

	assign beat_done = creq_valid && cresp_ready;
	assign unc_st = state == UNCACHED;

	always_comb begin
		state_nxt = state;
		cnt_nxt = cnt;
		case (state)
			CLEAR: begin
				cnt_nxt = cnt + 1'b1;
				if (cnt == INDEX_BITS'(NUM_LINES - 1)) begin
					state_nxt = IDLE;
					cnt_nxt = '0;
				end
			end
			IDLE: begin
				if (dreq_valid) begin
					if (!cached) begin
						state_nxt = UNCACHED;
					end else if (hit) begin
						state_nxt = HIT_RESP;
					end else if (line_valid) begin
						// no dirty bit, so any valid victim goes back to memory
						state_nxt = COPY;
					end else begin
						state_nxt = FETCH;
					end
				end
			end
			HIT_RESP: begin
				state_nxt = IDLE;
			end
			COPY: begin
				// four reads plus one cycle for the read latency
				cnt_nxt = cnt + 1'b1;
				if (cnt == INDEX_BITS'(WORDS_PER_LINE)) begin
					state_nxt = WRITEBACK;
					cnt_nxt = '0;
				end
			end
			WRITEBACK: begin
				if (beat_done) begin
					cnt_nxt = cnt + 1'b1;
					if (cresp_last) begin
						state_nxt = FETCH;
						cnt_nxt = '0;
					end
				end
			end
			FETCH: begin
				if (beat_done) begin
					cnt_nxt = cnt + 1'b1;
					if (cresp_last) begin
						// back to idle for the lookup that now hits
						state_nxt = IDLE;
						cnt_nxt = '0;
					end
				end
			end
			UNCACHED: begin
				if (beat_done) begin
					state_nxt = UNC_RESP;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CLEAR;
			cnt <= '0;
		end else begin
			state <= state_nxt;
			cnt <= cnt_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (unc_st && beat_done) begin
			unc_data <= cresp_data;
		end
	end

	// CPU response
	assign dresp_data_ok = state == HIT_RESP || state == UNC_RESP;
	assign dresp_data = state == UNC_RESP ? unc_data : data_rdata;

	// cache bus request
	assign creq_valid = state == WRITEBACK || state == FETCH || unc_st;
	assign creq_is_write = state == WRITEBACK || (unc_st && |dreq_strobe);
	assign creq_size = unc_st ? dreq_size : MSIZE8;
	assign creq_strobe = unc_st ? dreq_strobe : '1;
	assign creq_data = unc_st ? dreq_data : wb_rdata;
	assign creq_len = unc_st ? LEN_SINGLE : LEN_LINE;
	assign creq_burst = unc_st ? BURST_FIXED : BURST_INCR;

	always_comb begin
		case (state)
			WRITEBACK: creq_addr = {CACHED_REGION, line_tag, req.f.index, {OFFSET_BITS{1'b0}}};
			FETCH: creq_addr = {req.raw[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
			default: creq_addr = req.raw;
		endcase
	end

	// tag RAM, swept to invalid after reset
	assign tag_addr = state == CLEAR ? cnt : req.f.index;
	assign tag_wen = state == CLEAR || (state == FETCH && beat_done && cresp_last);
	assign tag_wdata = state == CLEAR ? '0 : {1'b1, req.f.tag};

	// data RAM
	assign data_addr = {req.f.index,
		(state == COPY || state == FETCH) ? cnt[WORD_BITS-1:0] : req.f.word};
	assign data_wdata = state == FETCH ? cresp_data : dreq_data;

	always_comb begin
		data_wen = '0;
		if (state == FETCH && beat_done) begin
			data_wen = '1;
		end else if (state == IDLE && dreq_valid && cached && hit) begin
			data_wen = dreq_strobe;
		end
	end

	// RAM word read at step n lands in the buffer at step n + 1
	assign wb_wr_en = state == COPY && cnt != '0;
	assign wb_wr_word = cnt[WORD_BITS-1:0] - 1'b1;
	assign wb_rd_word = cnt[WORD_BITS-1:0];

	a_creq_stable: assert property (
		@(posedge clk) disable iff (reset)
		creq_valid && !cresp_ready |=> creq_valid && $stable({creq_is_write, creq_size,
			creq_addr, creq_strobe, creq_len, creq_burst})
	) else $error("dcache_ctrl: request changed while a beat was stalled");

	a_last_on_beat3: assert property (
		@(posedge clk) disable iff (reset)
		beat_done && cresp_last && creq_len == LEN_LINE |-> cnt[WORD_BITS-1:0] == 2'd3
	) else $error("dcache_ctrl: last beat of a line burst arrived early");

	a_no_spurious_req: assert property (
		@(posedge clk) disable iff (reset)
		state == IDLE && !dreq_valid |=> !creq_valid
	) else $error("dcache_ctrl: bus request raised without a CPU request");

endmodule

// ==== dcache.sv ====
`timescale 1ns/1ps

module dcache
	import dcache_pkg::*;
(
	input logic clk,
	input logic reset,

	// data bus from the CPU
	input logic dreq_valid,
	input logic [ADDR_BITS-1:0] dreq_addr,
	input logic [2:0] dreq_size,
	input logic [STRB_BITS-1:0] dreq_strobe,
	input logic [DATA_BITS-1:0] dreq_data,
	output logic dresp_data_ok,
	output logic [DATA_BITS-1:0] dresp_data,

	// cache bus to memory
	output logic creq_valid,
	output logic creq_is_write,
	output logic [2:0] creq_size,
	output logic [ADDR_BITS-1:0] creq_addr,
	output logic [STRB_BITS-1:0] creq_strobe,
	output logic [DATA_BITS-1:0] creq_data,
	output logic [3:0] creq_len,
	output logic [1:0] creq_burst,
	input logic cresp_ready,
	input logic cresp_last,
	input logic [DATA_BITS-1:0] cresp_data
);

	logic [INDEX_BITS-1:0] tag_addr;
	logic tag_wen;
	logic [TAG_BITS:0] tag_wdata;
	logic [TAG_BITS:0] tag_rdata;

	logic [INDEX_BITS+WORD_BITS-1:0] data_addr;
	logic [STRB_BITS-1:0] data_wen;
	logic [DATA_BITS-1:0] data_wdata;
	logic [DATA_BITS-1:0] data_rdata;

	logic wb_wr_en;
	logic [WORD_BITS-1:0] wb_wr_word;
	logic [WORD_BITS-1:0] wb_rd_word;
	logic [DATA_BITS-1:0] wb_rdata;

	dcache_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.dreq_valid(dreq_valid),
		.dreq_addr(dreq_addr),
		.dreq_size(dreq_size),
		.dreq_strobe(dreq_strobe),
		.dreq_data(dreq_data),
		.dresp_data_ok(dresp_data_ok),
		.dresp_data(dresp_data),
		.creq_valid(creq_valid),
		.creq_is_write(creq_is_write),
		.creq_size(creq_size),
		.creq_addr(creq_addr),
		.creq_strobe(creq_strobe),
		.creq_data(creq_data),
		.creq_len(creq_len),
		.creq_burst(creq_burst),
		.cresp_ready(cresp_ready),
		.cresp_last(cresp_last),
		.cresp_data(cresp_data),
		.tag_addr(tag_addr),
		.tag_wen(tag_wen),
		.tag_wdata(tag_wdata),
		.tag_rdata(tag_rdata),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.wb_wr_en(wb_wr_en),
		.wb_wr_word(wb_wr_word),
		.wb_rd_word(wb_rd_word),
		.wb_rdata(wb_rdata)
	);

	// {valid, tag} per line, read in the lookup cycle
	dcache_ram #(
		.ADDR_WIDTH(INDEX_BITS),
		.DATA_WIDTH(TAG_BITS + 1),
		.BYTE_WIDTH(TAG_BITS + 1),
		.READ_LATENCY(0)
	) tag_ram (
		.clk(clk),
		.addr(tag_addr),
		.strobe(tag_wen),
		.wdata(tag_wdata),
		.rdata(tag_rdata)
	);

	dcache_ram #(
		.ADDR_WIDTH(INDEX_BITS + WORD_BITS),
		.DATA_WIDTH(DATA_BITS),
		.BYTE_WIDTH(8),
		.READ_LATENCY(1)
	) data_ram (
		.clk(clk),
		.addr(data_addr),
		.strobe(data_wen),
		.wdata(data_wdata),
		.rdata(data_rdata)
	);

	dcache_wb_buffer u_wb_buffer (
		.clk(clk),
		.wr_en(wb_wr_en),
		.wr_word(wb_wr_word),
		.wdata(data_rdata),
		.rd_word(wb_rd_word),
		.rdata(wb_rdata)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset held for 10 cycles, released just after an edge
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model
	import dcache_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic creq_valid,
	input logic creq_is_write,
	input logic [2:0] creq_size,
	input logic [ADDR_BITS-1:0] creq_addr,
	input logic [STRB_BITS-1:0] creq_strobe,
	input logic [DATA_BITS-1:0] creq_data,
	input logic [3:0] creq_len,
	input logic [1:0] creq_burst,
	output logic cresp_ready,
	output logic cresp_last,
	output logic [DATA_BITS-1:0] cresp_data,
	output int errors
);

	// word store indexed by address bit 31 and bits 12:3
	logic [DATA_BITS-1:0] mem [2048];
	logic [3:0] beat;
	logic [ADDR_BITS-1:0] beat_addr;

	function automatic logic [10:0] word_idx(input logic [ADDR_BITS-1:0] a);
		return {a[31], a[12:3]};
	endfunction

	// every word differs, so a wrong address shows up as wrong data
	function automatic logic [DATA_BITS-1:0] fill_word(input logic [ADDR_BITS-1:0] a);
		return {a ^ 32'h5a3c_96e1, ~a};
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	assign beat_addr = creq_addr + {beat, 3'b000};

	initial begin
		errors = 0;
		beat = '0;
		cresp_ready = 1'b0;
		cresp_last = 1'b0;
		cresp_data = '0;
		for (int i = 0; i < 2048; i++) begin
			mem[i] = fill_word({i[10], 18'd0, i[9:0], 3'd0});
		end
		void'($urandom(25));
		forever begin
			@(posedge clk);
			if (reset) begin
				beat = '0;
			end else if (creq_valid && cresp_ready) begin
				for (int b = 0; b < STRB_BITS; b++) begin
					if (creq_is_write && creq_strobe[b]) begin
						mem[word_idx(beat_addr)][b*8 +: 8] = creq_data[b*8 +: 8];
					end
				end
				beat = cresp_last ? 4'd0 : beat + 4'd1;
			end
			#1;
			// ready about three cycles in four
			cresp_ready = ($urandom % 4) != 0;
			cresp_last = creq_valid && beat == creq_len;
			cresp_data = mem[word_idx(beat_addr)];
		end
	end

	a_stall_stable: assert property (@(posedge clk) disable iff (reset)
		creq_valid && !cresp_ready |=> creq_valid && $stable({creq_is_write, creq_size,
			creq_addr, creq_strobe, creq_len, creq_burst}))
		else report_error("request field changed while a beat was stalled");

	a_line_shape: assert property (@(posedge clk) disable iff (reset)
		creq_valid && creq_len == LEN_LINE |-> creq_burst == BURST_INCR
			&& creq_size == MSIZE8 && creq_addr[4:0] == 5'd0
			&& creq_addr[31:28] == CACHED_REGION)
		else report_error("line burst is not an aligned 8-byte INCR burst");

	a_single_ends: assert property (@(posedge clk) disable iff (reset)
		creq_valid && cresp_ready && creq_len == LEN_SINGLE |=> !creq_valid)
		else report_error("single beat request stayed up after its beat");

	a_wb_then_fill: assert property (@(posedge clk) disable iff (reset)
		creq_valid && cresp_ready && cresp_last && creq_is_write && creq_len == LEN_LINE
			|=> creq_valid && !creq_is_write && creq_len == LEN_LINE)
		else report_error("write burst not followed by a line read");

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache
	import dcache_pkg::*;
();

	localparam int TIMEOUT = 400;

	logic clk;
	logic reset;
	logic dreq_valid;
	logic [ADDR_BITS-1:0] dreq_addr;
	logic [2:0] dreq_size;
	logic [STRB_BITS-1:0] dreq_strobe;
	logic [DATA_BITS-1:0] dreq_data;
	logic dresp_data_ok;
	logic [DATA_BITS-1:0] dresp_data;
	logic creq_valid;
	logic creq_is_write;
	logic [2:0] creq_size;
	logic [ADDR_BITS-1:0] creq_addr;
	logic [STRB_BITS-1:0] creq_strobe;
	logic [DATA_BITS-1:0] creq_data;
	logic [3:0] creq_len;
	logic [1:0] creq_burst;
	logic cresp_ready;
	logic cresp_last;
	logic [DATA_BITS-1:0] cresp_data;
	int model_errors;

	// reference state: word image of memory and the expected tag of each line
	logic [DATA_BITS-1:0] shadow [2048];
	logic line_valid [NUM_LINES];
	logic [TAG_BITS-1:0] line_tag [NUM_LINES];
	logic req_active;
	logic expect_hit;
	logic checks_on;
	logic [DATA_BITS-1:0] exp_data;
	logic [ADDR_BITS-1:0] exp_wb_addr;
	logic [31:0] rnd;
	int wr_beat;
	int rd_bursts;
	int wr_bursts;
	int singles;
	int errors;
	int passed;
	int failed;
	int mark;

	tb_clock_gen i_clk (.clk(clk), .reset(reset));
	tb_mem_model i_mem (.errors(model_errors), .*);
	dcache i_dut (.*);

	function automatic logic [10:0] word_idx(input logic [ADDR_BITS-1:0] a);
		return {a[31], a[12:3]};
	endfunction

	function automatic logic [DATA_BITS-1:0] fill_word(input logic [ADDR_BITS-1:0] a);
		return {a ^ 32'h5a3c_96e1, ~a};
	endfunction

	function automatic int total_errors();
		return errors + model_errors;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic end_test(input string name);
		if (total_errors() == mark) begin
			passed++;
			$display("test %s: passed", name);
		end else begin
			failed++;
			$display("test %s: failed with %0d errors", name, total_errors() - mark);
		end
		mark = total_errors();
	endtask

	a_quiet: assert property (@(posedge clk) checks_on && !req_active
		|-> !creq_valid && !dresp_data_ok)
		else report_error("bus request or response with no CPU request");

	a_load_data: assert property (@(posedge clk) disable iff (reset)
		dresp_data_ok && dreq_strobe == '0 |-> dresp_data == exp_data)
		else report_error("load data differs from shadow memory");

	a_hit_latency: assert property (@(posedge clk) disable iff (reset)
		$rose(dreq_valid) && expect_hit |=> dresp_data_ok)
		else report_error("hit did not answer one cycle after valid");

	a_hit_no_bus: assert property (@(posedge clk) disable iff (reset)
		dreq_valid && expect_hit |-> !creq_valid)
		else report_error("cache bus used during a hit");

	a_fill_addr: assert property (@(posedge clk) disable iff (reset)
		creq_valid && !creq_is_write && creq_len == LEN_LINE
			|-> creq_addr == {dreq_addr[31:5], 5'd0})
		else report_error("line fill address is not the requested line");

	a_uncached: assert property (@(posedge clk) disable iff (reset)
		creq_valid && creq_addr[31:28] != CACHED_REGION |-> creq_len == LEN_SINGLE
			&& creq_burst == BURST_FIXED && creq_addr == dreq_addr
			&& creq_size == dreq_size && creq_strobe == dreq_strobe
			&& creq_is_write == (dreq_strobe != '0)
			&& (dreq_strobe == '0 || creq_data == dreq_data))
		else report_error("uncached beat does not match the request");

	// counts bursts and checks each writeback beat
	always @(posedge clk) begin
		if (!reset && creq_valid && cresp_ready) begin
			if (creq_len == LEN_SINGLE) begin
				singles++;
			end else if (creq_is_write) begin
				assert (creq_addr == exp_wb_addr)
					else report_error("writeback address is not the old line");
				assert (creq_data == shadow[word_idx(creq_addr) + wr_beat])
					else report_error("writeback data differs from shadow memory");
				wr_beat = cresp_last ? 0 : wr_beat + 1;
				wr_bursts += cresp_last;
			end else begin
				rd_bursts += cresp_last;
			end
		end
	end

	// one request, started and ended 1 ns after a rising edge
	task automatic do_access(input logic [ADDR_BITS-1:0] addr, input logic [2:0] size,
		input logic [STRB_BITS-1:0] strobe, input logic [DATA_BITS-1:0] data);
		dcache_addr_u a;
		logic cached;
		logic victim;
		int rd0;
		int wr0;
		int sg0;
		int cycles;
		a.raw = addr;
		cached = a.f.region == CACHED_REGION;
		victim = cached && line_valid[a.f.index] && line_tag[a.f.index] != a.f.tag;
		expect_hit = cached && line_valid[a.f.index] && line_tag[a.f.index] == a.f.tag;
		exp_wb_addr = {CACHED_REGION, line_tag[a.f.index], a.f.index, 5'd0};
		for (int b = 0; b < STRB_BITS; b++) begin
			if (strobe[b]) begin
				shadow[word_idx(addr)][b*8 +: 8] = data[b*8 +: 8];
			end
		end
		exp_data = shadow[word_idx(addr)];
		rd0 = rd_bursts;
		wr0 = wr_bursts;
		sg0 = singles;
		dreq_addr = addr;
		dreq_size = size;
		dreq_strobe = strobe;
		dreq_data = data;
		dreq_valid = 1'b1;
		req_active = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!dresp_data_ok && cycles < TIMEOUT);
		if (!dresp_data_ok) begin
			$display("timeout: no data-ok within %0d cycles for address %h", TIMEOUT, addr);
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			#1;
			dreq_valid = 1'b0;
			req_active = 1'b0;
			if (cached) begin
				assert (rd_bursts - rd0 == (expect_hit ? 0 : 1))
					else report_error("wrong number of line fills");
				assert (wr_bursts - wr0 == (victim ? 1 : 0))
					else report_error("wrong number of writebacks");
				if (victim) begin
					for (int k = 0; k < WORDS_PER_LINE; k++) begin
						assert (i_mem.mem[word_idx(exp_wb_addr) + k]
							== shadow[word_idx(exp_wb_addr) + k])
							else report_error("memory differs from old line after writeback");
					end
				end
				line_valid[a.f.index] = 1'b1;
				line_tag[a.f.index] = a.f.tag;
			end else begin
				assert (singles - sg0 == 1) else report_error("uncached access not one beat");
			end
			expect_hit = 1'b0;
			// idle cycle so the next valid is a fresh rise
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		dreq_valid = 1'b0;
		dreq_addr = '0;
		dreq_size = MSIZE8;
		dreq_strobe = '0;
		dreq_data = '0;
		req_active = 1'b0;
		expect_hit = 1'b0;
		checks_on = 1'b0;
		exp_data = '0;
		exp_wb_addr = '0;
		wr_beat = 0;
		rd_bursts = 0;
		wr_bursts = 0;
		singles = 0;
		errors = 0;
		passed = 0;
		failed = 0;
		mark = 0;
		for (int i = 0; i < 2048; i++) begin
			shadow[i] = fill_word({i[10], 18'd0, i[9:0], 3'd0});
		end
		for (int i = 0; i < NUM_LINES; i++) begin
			line_valid[i] = 1'b0;
		end
		@(posedge clk);
		#1;
		checks_on = 1'b1;
		// 10 reset cycles, then the 16-cycle tag sweep
		repeat (30) @(posedge clk);
		#1;
		do_access(32'h8000_0040, MSIZE8, 8'h00, '0);
		end_test("reset and first miss");

		do_access(32'h8000_0100, MSIZE8, 8'h00, '0);
		do_access(32'h8000_0108, MSIZE8, 8'h00, '0);
		do_access(32'h8000_0118, MSIZE8, 8'h00, '0);
		end_test("miss fill and hit");

		do_access(32'h8000_0108, MSIZE8, 8'h0f, 64'h1111_2222_3333_4444);
		do_access(32'h8000_0108, MSIZE8, 8'h00, '0);
		do_access(32'h8000_0108, MSIZE8, 8'hc3, 64'hdead_beef_cafe_f00d);
		do_access(32'h8000_0108, MSIZE8, 8'h00, '0);
		do_access(32'h8000_0110, MSIZE8, 8'h81, 64'h0123_4567_89ab_cdef);
		do_access(32'h8000_0110, MSIZE8, 8'h00, '0);
		end_test("store merge");

		// same index 8, other tags
		do_access(32'h8000_0310, MSIZE8, 8'h00, '0);
		do_access(32'h8000_0108, MSIZE8, 8'h00, '0);
		do_access(32'h8000_0500, MSIZE8, 8'h3c, 64'h5555_aaaa_5555_aaaa);
		end_test("conflict writeback");

		do_access(32'h0000_0040, MSIZE8, 8'h00, '0);
		do_access(32'h0000_004c, MSIZE4, 8'hf0, 64'h8765_4321_0000_0000);
		do_access(32'h0000_004c, MSIZE4, 8'h00, '0);
		do_access(32'h0000_0042, MSIZE1, 8'h04, 64'h0000_0000_00a5_0000);
		do_access(32'h0000_0040, MSIZE8, 8'h00, '0);
		end_test("uncached pass-through");

		for (int n = 0; n < 200; n++) begin
			rnd = $urandom;
			do_access({((rnd[1:0] == 2'd0) ? 4'h0 : CACHED_REGION), 17'd0, rnd[3:2],
				rnd[7:4], rnd[9:8], 3'd0}, MSIZE8, rnd[10] ? rnd[18:11] : 8'h00,
				{$urandom, $urandom});
		end
		end_test("back-pressure random mix");

		$display("tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0 && total_errors() == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
dcache_pkg.sv
dcache_ram.sv
dcache_wb_buffer.sv
dcache_ctrl.sv
dcache.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_dcache.sv
